// File: sources.f
+incdir+verilog
verilog/stream_pkg.sv
verilog/regs_pkg.sv
verilog/dual_port_ram.sv
verilog/bram_stream_fifo.sv
verilog/buffer_ctrl_regs.sv
verilog/stream_buffer_top.sv
tb/stream_buffer_props.sv
tb/stream_buffer_tb.sv

// File: tb/stream_buffer_tb.sv
/* stream buffer testbench */

`include "stream_buffer_cfg.svh"

module stream_buffer_tb;

   localparam int depth = `SB_DEPTH;

   typedef enum logic [2:0]
   {
      op_push, op_stall, op_fill, op_drain, op_latency, op_write, op_read
   } op_t;

   // one table row where value is write data or expected read data
   typedef struct packed {
      op_t         op;
      logic [15:0] arg;
      logic [31:0] value;
      logic        use_model;
   } step_t;

   logic                clk;
   logic                reset;
   stream_pkg::data_t   in_data;
   logic                in_valid;
   logic                in_ready;
   stream_pkg::data_t   out_data;
   logic                out_valid;
   logic                out_ready;
   regs_pkg::reg_req_t  reg_req;
   regs_pkg::reg_data_t reg_rdata;
   logic                above_thresh;

   step_t             steps[$];
   stream_pkg::data_t model_q[$];
   int                model_max;
   int                model_thresh;
   logic              clear_pending;
   integer            seed;
   int                checks;
   int                errors;
   int                cycle_count;
   int                cycle_limit;

   stream_buffer_top dut
   (
      .clk            (clk),
      .reset          (reset),
      .i_in_data      (in_data),
      .i_in_valid     (in_valid),
      .o_in_ready     (in_ready),
      .o_out_data     (out_data),
      .o_out_valid    (out_valid),
      .i_out_ready    (out_ready),
      .i_reg          (reg_req),
      .o_reg_rdata    (reg_rdata),
      .o_above_thresh (above_thresh)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // watchdog
   initial
   begin
      @(posedge clk);
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Something failed");
      $finish;
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      begin
         checks++;
         if (actual !== expected)
         begin
            errors++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
         end
      end
   endtask

   task automatic report_failure(input string what);
      begin
         errors++;
         $display("ERROR: %s", what);
      end
   endtask

   function automatic void add_step(op_t kind, int arg, int value, logic use_model);
      step_t s;
      s.op        = kind;
      s.arg       = arg[15:0];
      s.value     = value;
      s.use_model = use_model;
      steps.push_back(s);
   endfunction

   function automatic string op_label(op_t kind);
      case (kind)
         op_push:    return "push";
         op_stall:   return "stall";
         op_fill:    return "fill";
         op_drain:   return "drain";
         op_latency: return "latency";
         op_write:   return "write";
         default:    return "read";
      endcase
   endfunction

   function automatic string reg_label(regs_pkg::reg_addr_t addr);
      case (addr)
         `SB_REG_THRESH:    return "o_reg_rdata(threshold)";
         `SB_REG_SPACE:     return "o_reg_rdata(space)";
         `SB_REG_OCCUPIED:  return "o_reg_rdata(occupied)";
         `SB_REG_HIGHWATER: return "o_reg_rdata(high-water)";
         default:           return "o_reg_rdata";
      endcase
   endfunction

   // register contents as the model sees them
   function automatic logic [31:0] model_reg(regs_pkg::reg_addr_t addr);
      case (addr)
         `SB_REG_THRESH:    return model_thresh;
         `SB_REG_SPACE:     return depth - model_q.size();
         `SB_REG_OCCUPIED:  return model_q.size();
         `SB_REG_HIGHWATER: return model_max;
         default:           return 0;
      endcase
   endfunction

   // runs from one falling edge with inputs set to the next falling edge
   task automatic clock_step(output logic accepted);
      int                occ_before;
      int                thresh_before;
      logic              deliver;
      stream_pkg::data_t expected_word;
      begin
         accepted      = in_valid && in_ready;
         deliver       = out_valid && out_ready;
         occ_before    = model_q.size();
         thresh_before = model_thresh;
         if (deliver)
         begin
            if (model_q.size() == 0)
               report_failure("output delivered a word that was never accepted");
            else
            begin
               expected_word = model_q.pop_front();
               check_value("o_out_data", out_data, expected_word);
            end
         end
         if (accepted)
            model_q.push_back(in_data);
         // clear lands one edge after the ctrl write
         if (clear_pending)
         begin
            model_q.delete();
            model_max = 0;
         end
         clear_pending = reg_req.wr && (reg_req.addr == `SB_REG_CTRL) && reg_req.wdata[0];
         if (reg_req.wr && (reg_req.addr == `SB_REG_THRESH))
            model_thresh = reg_req.wdata;
         if (model_q.size() > model_max)
            model_max = model_q.size();
         @(negedge clk);
         check_value("o_above_thresh", above_thresh, occ_before >= thresh_before);
      end
   endtask

   task automatic push_words(input int count, input logic random_ready);
      int          done;
      logic        accepted;
      logic [31:0] rnd;
      begin
         done     = 0;
         in_valid = 1'b1;
         in_data  = $random(seed);
         while (done < count)
         begin
            rnd       = $random(seed);
            out_ready = random_ready & rnd[0];
            clock_step(accepted);
            if (accepted)
            begin
               done++;
               in_data = $random(seed);
            end
         end
         in_valid  = 1'b0;
         out_ready = 1'b0;
      end
   endtask

   task automatic fill_fifo();
      int   done;
      int   tries;
      logic accepted;
      begin
         done      = 0;
         tries     = 0;
         out_ready = 1'b0;
         in_valid  = 1'b1;
         in_data   = $random(seed);
         while (in_ready && tries < 2 * depth)
         begin
            clock_step(accepted);
            tries++;
            if (accepted)
            begin
               done++;
               in_data = $random(seed);
            end
         end
         in_valid = 1'b0;
         if (in_ready)
            report_failure("input ready never fell while the output was stalled");
         else if (done < depth - 2)
            report_failure($sformatf("input ready fell after only %0d words", done));
      end
   endtask

   task automatic drain_fifo();
      logic accepted;
      begin
         in_valid  = 1'b0;
         out_ready = 1'b1;
         while (model_q.size() > 0)
            clock_step(accepted);
         out_ready = 1'b0;
         check_value("o_out_valid", out_valid, 1'b0);
      end
   endtask

   // count cycles from the accepting edge to output valid
   task automatic measure_latency();
      int   cycles;
      logic accepted;
      begin
         cycles    = 0;
         accepted  = 1'b0;
         out_ready = 1'b1;
         in_valid  = 1'b1;
         in_data   = $random(seed);
         while (!accepted)
            clock_step(accepted);
         in_valid = 1'b0;
         while (!out_valid && cycles < 8)
         begin
            clock_step(accepted);
            cycles++;
         end
         check_value("o_out_valid latency", cycles, 3);
      end
   endtask

   task automatic reg_write(input regs_pkg::reg_addr_t addr, input regs_pkg::reg_data_t data);
      logic accepted;
      begin
         reg_req.wr    = 1'b1;
         reg_req.addr  = addr;
         reg_req.wdata = data;
         clock_step(accepted);
         reg_req.wr = 1'b0;
         clock_step(accepted);
      end
   endtask

   task automatic reg_read(input regs_pkg::reg_addr_t addr, input logic [31:0] expected);
      logic accepted;
      begin
         // one idle cycle so the high-water mark catches up
         clock_step(accepted);
         reg_req.rd   = 1'b1;
         reg_req.addr = addr;
         clock_step(accepted);
         reg_req.rd = 1'b0;
         check_value(reg_label(addr), reg_rdata, expected);
      end
   endtask

   initial
   begin
      int                  total_words;
      regs_pkg::reg_addr_t addr;
      reset         = 1'b1;
      in_data       = '0;
      in_valid      = 1'b0;
      out_ready     = 1'b0;
      reg_req       = '0;
      seed          = 32'h724a;
      checks        = 0;
      errors        = 0;
      model_max     = 0;
      model_thresh  = depth / 2;
      clear_pending = 1'b0;
      cycle_count   = 0;

      add_step(op_push, 24, 0, 0);
      add_step(op_drain, 0, 0, 0);
      add_step(op_latency, 1, 0, 0);
      add_step(op_drain, 0, 0, 0);
      add_step(op_fill, depth, 0, 0);
      add_step(op_read, `SB_REG_OCCUPIED, 0, 1);
      add_step(op_read, `SB_REG_SPACE, 0, 1);
      add_step(op_read, `SB_REG_HIGHWATER, 0, 1);
      add_step(op_drain, 0, 0, 0);
      add_step(op_read, `SB_REG_HIGHWATER, 0, 1);
      add_step(op_read, `SB_REG_OCCUPIED, 0, 0);
      add_step(op_write, `SB_REG_THRESH, 5, 0);
      add_step(op_read, `SB_REG_THRESH, 5, 0);
      add_step(op_push, 20, 0, 0);
      add_step(op_drain, 0, 0, 0);
      add_step(op_stall, 7, 0, 0);
      add_step(op_write, `SB_REG_CTRL, 1, 0);
      add_step(op_read, `SB_REG_OCCUPIED, 0, 0);
      add_step(op_read, `SB_REG_SPACE, depth, 0);
      add_step(op_read, `SB_REG_HIGHWATER, 0, 0);
      add_step(op_push, 12, 0, 0);
      add_step(op_drain, 0, 0, 0);
      add_step(op_read, `SB_REG_HIGHWATER, 0, 1);

      total_words = 0;
      foreach (steps[i])
         if (steps[i].op inside {op_push, op_stall, op_fill, op_latency})
            total_words += steps[i].arg;
      cycle_limit = 4 * total_words + 200;

      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      foreach (steps[i])
      begin
         addr = regs_pkg::reg_addr_t'(steps[i].arg);
         case (steps[i].op)
            op_push:    push_words(steps[i].arg, 1'b1);
            op_stall:   push_words(steps[i].arg, 1'b0);
            op_fill:    fill_fifo();
            op_drain:   drain_fifo();
            op_latency: measure_latency();
            op_write:   reg_write(addr, steps[i].value[15:0]);
            default:    reg_read(addr, steps[i].use_model ? model_reg(addr) : steps[i].value);
         endcase
         $display("step %0d %s %0d finished, %0d errors so far",
                  i, op_label(steps[i].op), steps[i].arg, errors);
      end

      if (dut.fifo.props.assert_failures > 0)
      begin
         errors += dut.fifo.props.assert_failures;
         $display("ERROR: %0d assertion failures on the FIFO flags or handshake",
                  dut.fifo.props.assert_failures);
      end

      $display("%0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: tb/stream_buffer_props.sv
/* fifo flag and handshake assertions */

`include "stream_buffer_cfg.svh"

module stream_buffer_props
(
   input logic                     clk,
   input logic                     reset,
   input logic                     i_clear,
   input logic                     i_out_valid,
   input stream_pkg::data_t        i_out_data,
   input logic                     i_out_ready,
   input stream_pkg::fifo_status_t i_status
);

   // number of assertion failures so far
   int assert_failures = 0;

   // a stalled output word must wait for the sink
   hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
      (i_out_valid && !i_out_ready && !i_clear) |=> (i_out_valid && $stable(i_out_data)))
      else
      begin
         assert_failures++;
         $error("output word or valid changed under back-pressure");
      end

   clear_drops_valid: assert property (@(posedge clk) disable iff (reset)
      i_clear |=> !i_out_valid)
      else
      begin
         assert_failures++;
         $error("output valid still high after clear");
      end

   // space and occupied always add up to the depth
   levels_add_up: assert property (@(posedge clk) disable iff (reset)
      (int'(i_status.space) + int'(i_status.occupied)) == `SB_DEPTH)
      else
      begin
         assert_failures++;
         $error("space plus occupied differs from the depth");
      end

endmodule

bind bram_stream_fifo stream_buffer_props props
(
   .clk         (clk),
   .reset       (reset),
   .i_clear     (i_clear),
   .i_out_valid (o_out_valid),
   .i_out_data  (o_out_data),
   .i_out_ready (i_out_ready),
   .i_status    (o_status)
);

// File: verilog/stream_buffer_top.sv
/* stream buffer top */

module stream_buffer_top
(
   input  logic                clk,
   input  logic                reset,
   input  stream_pkg::data_t   i_in_data,
   input  logic                i_in_valid,
   output logic                o_in_ready,
   output stream_pkg::data_t   o_out_data,
   output logic                o_out_valid,
   input  logic                i_out_ready,
   input  regs_pkg::reg_req_t  i_reg,
   output regs_pkg::reg_data_t o_reg_rdata,
   output logic                o_above_thresh
);

   logic                     clear;
   stream_pkg::fifo_status_t status;

   buffer_ctrl_regs regs
   (
      .clk            (clk),
      .reset          (reset),
      .i_reg          (i_reg),
      .i_status       (status),
      .o_reg_rdata    (o_reg_rdata),
      .o_clear        (clear),
      .o_above_thresh (o_above_thresh)
   );

   bram_stream_fifo fifo
   (
      .clk         (clk),
      .reset       (reset),
      .i_clear     (clear),
      .i_in_data   (i_in_data),
      .i_in_valid  (i_in_valid),
      .o_in_ready  (o_in_ready),
      .o_out_data  (o_out_data),
      .o_out_valid (o_out_valid),
      .i_out_ready (i_out_ready),
      .o_status    (status)
   );

endmodule

// File: verilog/buffer_ctrl_regs.sv
/* stream buffer control registers */

`include "stream_buffer_cfg.svh"

module buffer_ctrl_regs
(
   input  logic                     clk,
   input  logic                     reset,
   input  regs_pkg::reg_req_t       i_reg,
   input  stream_pkg::fifo_status_t i_status,
   output regs_pkg::reg_data_t      o_reg_rdata,
   output logic                     o_clear,
   output logic                     o_above_thresh
);

   localparam stream_pkg::level_t thresh_init = stream_pkg::level_t'(`SB_DEPTH / 2);

   stream_pkg::level_t thresh;
   stream_pkg::level_t high_water;
   logic               ctrl_wr;
   logic               thresh_wr;

   // write decode
   assign ctrl_wr   = i_reg.wr && (i_reg.addr == `SB_REG_CTRL);
   assign thresh_wr = i_reg.wr && (i_reg.addr == `SB_REG_THRESH);

   // one-cycle clear pulse after the ctrl write
   always_ff @(posedge clk)
   begin
      if (reset)
         o_clear <= 1'b0;
      else
         o_clear <= ctrl_wr && i_reg.wdata[0];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         thresh <= thresh_init;
      else if (thresh_wr)
         thresh <= i_reg.wdata;
   end

   // peak occupancy since reset or clear
   always_ff @(posedge clk)
   begin
      if (reset || o_clear)
         high_water <= '0;
      else if (i_status.occupied > high_water)
         high_water <= i_status.occupied;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         o_above_thresh <= 1'b0;
      else
         o_above_thresh <= (i_status.occupied >= thresh);
   end

   // read-back, held until the next read strobe
   always_ff @(posedge clk)
   begin
      if (reset)
         o_reg_rdata <= '0;
      else if (i_reg.rd)
      begin
         case (i_reg.addr)
            `SB_REG_THRESH:    o_reg_rdata <= thresh;
            `SB_REG_SPACE:     o_reg_rdata <= i_status.space;
            `SB_REG_OCCUPIED:  o_reg_rdata <= i_status.occupied;
            `SB_REG_HIGHWATER: o_reg_rdata <= high_water;
            // ctrl is write-only
            default:           o_reg_rdata <= '0;
         endcase
      end
   end

endmodule

// File: verilog/bram_stream_fifo.sv
/* block ram stream fifo */

`include "stream_buffer_cfg.svh"

module bram_stream_fifo
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     i_clear,
   input  stream_pkg::data_t        i_in_data,
   input  logic                     i_in_valid,
   output logic                     o_in_ready,
   output stream_pkg::data_t        o_out_data,
   output logic                     o_out_valid,
   input  logic                     i_out_ready,
   output stream_pkg::fifo_status_t o_status
);

   localparam stream_pkg::level_t num_lines = stream_pkg::level_t'(`SB_DEPTH);

   stream_pkg::addr_t     wr_addr;
   stream_pkg::addr_t     wr_addr_next;
   stream_pkg::addr_t     rd_addr;
   stream_pkg::addr_t     ram_rd_addr;
   stream_pkg::addr_t     write_limit;
   stream_pkg::data_t     int_data;
   stream_pkg::rd_state_t rd_state;
   stream_pkg::level_t    space;
   stream_pkg::level_t    occupied;
   logic                  empty_reg;
   logic                  full_reg;
   logic                  write;
   logic                  read;
   logic                  int_ready;
   logic                  read_int;
   logic                  fetch;
   logic                  becoming_full;

   // handshakes at the two ports
   assign write = i_in_valid & o_in_ready;
   assign read  = o_out_valid & i_out_ready;

   // output register can take a word when empty or being taken
   assign int_ready = i_out_ready | ~o_out_valid;
   assign read_int  = ~empty_reg & int_ready;

   assign o_in_ready = ~full_reg;

   assign wr_addr_next = wr_addr + 1'b1;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         wr_addr <= '0;
      else if (write)
         wr_addr <= wr_addr_next;
   end

   // fetch the next line only when the internal stage moves,
   // otherwise keep re-reading the line it already holds
   assign fetch = (rd_state == stream_pkg::pre_read) |
                  ((rd_state == stream_pkg::reading) & read_int);
   assign ram_rd_addr = fetch ? rd_addr : rd_addr - 1'b1;

   dual_port_ram ram
   (
      .clk       (clk),
      .i_wr_en   (write),
      .i_wr_addr (wr_addr),
      .i_wr_data (i_in_data),
      .i_rd_addr (ram_rd_addr),
      .o_rd_data (int_data)
   );

   // read side, rd_addr always points one past the word in int_data
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         rd_state  <= stream_pkg::empty;
         rd_addr   <= '0;
         empty_reg <= 1'b1;
      end
      else
      begin
         case (rd_state)
            stream_pkg::empty:
               if (rd_addr != wr_addr)
                  rd_state <= stream_pkg::pre_read;
            stream_pkg::pre_read:
            begin
               rd_state  <= stream_pkg::reading;
               empty_reg <= 1'b0;
               rd_addr   <= rd_addr + 1'b1;
            end
            stream_pkg::reading:
               if (read_int)
               begin
                  if (rd_addr == wr_addr)
                  begin
                     // last word handed on, refetch from empty
                     empty_reg <= 1'b1;
                     rd_state  <= stream_pkg::empty;
                  end
                  else
                     rd_addr <= rd_addr + 1'b1;
               end
            default:
               rd_state <= stream_pkg::empty;
         endcase
      end
   end

   // stop two lines short of the read pointer, so ram plus the
   // two register stages never hold more than the depth
   assign write_limit   = rd_addr - 2'd2;
   assign becoming_full = (wr_addr_next == write_limit);

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         full_reg <= 1'b0;
      else if (read_int && !write)
         full_reg <= 1'b0;
      else if (write && !read_int && becoming_full)
         full_reg <= 1'b1;
   end

   // output register stage
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         o_out_valid <= 1'b0;
      else if (int_ready)
         o_out_valid <= ~empty_reg;
   end

   always_ff @(posedge clk)
   begin
      if (int_ready)
         o_out_data <= int_data;
   end

   // exact levels from the port handshakes
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         occupied <= '0;
         space    <= num_lines;
      end
      else if (write && !read)
      begin
         occupied <= occupied + 1'b1;
         space    <= space - 1'b1;
      end
      else if (read && !write)
      begin
         occupied <= occupied - 1'b1;
         space    <= space + 1'b1;
      end
   end

   assign o_status.space    = space;
   assign o_status.occupied = occupied;

endmodule

// File: verilog/dual_port_ram.sv
/* simple dual-port block ram */

`include "stream_buffer_cfg.svh"

module dual_port_ram
(
   input  logic              clk,
   input  logic              i_wr_en,
   input  stream_pkg::addr_t i_wr_addr,
   input  stream_pkg::data_t i_wr_data,
   input  stream_pkg::addr_t i_rd_addr,
   output stream_pkg::data_t o_rd_data
);

   stream_pkg::data_t mem [`SB_DEPTH];

   always_ff @(posedge clk)
   begin
      if (i_wr_en)
         mem[i_wr_addr] <= i_wr_data;
   end

   // registered read, one cycle after the address
   always_ff @(posedge clk)
   begin
      o_rd_data <= mem[i_rd_addr];
   end

endmodule

// File: verilog/regs_pkg.sv
/* register port types */

package regs_pkg;

   // register select
   typedef logic [2:0] reg_addr_t;

   // register contents
   typedef logic [15:0] reg_data_t;

   // strobe-driven request from outside
   typedef struct packed {
      logic      wr;
      logic      rd;
      reg_addr_t addr;
      reg_data_t wdata;
   } reg_req_t;

   // wr and rd are single-cycle strobes,
   // a read answers on the following edge

endpackage

// File: verilog/stream_pkg.sv
/* stream datapath types */

`include "stream_buffer_cfg.svh"

package stream_pkg;

   // one stream word
   typedef logic [`SB_DATA_WIDTH-1:0] data_t;

   // ram line address
   typedef logic [`SB_ADDR_WIDTH-1:0] addr_t;

   // word count
   typedef logic [15:0] level_t;

   // fifo fill status
   typedef struct packed {
      level_t space;
      level_t occupied;
   } fifo_status_t;

   // read side of the fifo
   typedef enum logic [1:0] {empty, pre_read, reading} rd_state_t;

endpackage

// File: verilog/stream_buffer_cfg.svh
/* stream buffer configuration */

`ifndef STREAM_BUFFER_CFG_SVH
`define STREAM_BUFFER_CFG_SVH

// width of one stream word
`define SB_DATA_WIDTH 32

// ram address width, 16 lines
`define SB_ADDR_WIDTH 4

// number of ram lines
`define SB_DEPTH (1 << `SB_ADDR_WIDTH)

// register map
// ctrl bit 0 pulses the fifo clear
`define SB_REG_CTRL      3'd0
`define SB_REG_THRESH    3'd1
// read-only status
`define SB_REG_SPACE     3'd2
`define SB_REG_OCCUPIED  3'd3
`define SB_REG_HIGHWATER 3'd4

`endif
